/* hw/hostPkg.sv */
// Host interface definitions
// Bus widths, parameter register indices, output address constants,
// buffer sizing and the state encodings of the run control FSMs
package hostPkg;

	// Word address into the input or the output memory
	typedef logic [10:0] memAddrT;

	// Data word on the register and memory buses
	typedef logic [31:0] hostWordT;

	// Parameter register address
	typedef logic [7:0] regAddrT;

	// Register holding the number of words to stream
	localparam regAddrT lengthRegIndex = 8'd0;

	// Register holding the multiplier, only the low byte is used
	localparam regAddrT multiplierRegIndex = 8'd1;

	// Top output word, receives the cycle count of a run
	localparam memAddrT cycleCountAddress = 11'd2047;

	// Longest run, data stays below the cycle count word
	localparam memAddrT maxLength = 11'd2047;

	// Both FIFOs hold 32 words
	localparam int fifoLogDepth = 5;

	// FIFO occupancy, one bit wider than the pointers
	typedef logic [fifoLogDepth:0] fifoCountT;

	// Parameter fetch FSM
	typedef enum logic [1:0] {decodeIdle, decodeFetching, decodeRunning} decodeStateT;

	// Output writer FSM, finishing is also the rest state between runs
	typedef enum logic [1:0] {writerStreaming, writerReporting, writerFinishing} writerStateT;

endpackage

/* hw/gfMathPkg.sv */
// GF(2^8) arithmetic definitions
// Field element and lane word types plus the reduction polynomial
// used by the byte-lane multiplier
package gfMathPkg;

	// One field element, one byte
	typedef logic [7:0] gfElemT;

	// Byte lanes per 32-bit word
	localparam int laneCount = 4;

	// A host word viewed as independent field elements
	// Lane 0 is the low byte
	typedef gfElemT [laneCount-1:0] gfWordT;

	// x^8 + x^4 + x^3 + x + 1
	localparam logic [8:0] fieldPoly = 9'h11B;

endpackage

/* hw/streamFifo.sv */
// Synchronous FIFO
// Circular buffer with read and write pointers and an occupancy count,
// read data is taken from the head entry without a cycle of delay
`timescale 1ns/1ps

module streamFifo #(
	parameter int dataWidth = 32,
	parameter int logDepth = 5
) (
	input logic clk,
	input logic reset,
	input logic [dataWidth-1:0] dataIn,
	input logic push,
	input logic pop,
	output logic [dataWidth-1:0] dataOut,
	output logic empty,
	output logic [logDepth:0] count
);

	logic [dataWidth-1:0] mem [0:(1 << logDepth) - 1];
	// Pointers wrap on their own width
	logic [logDepth-1:0] readPtr;
	logic [logDepth-1:0] writePtr;

	// Storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[writePtr] <= dataIn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				writePtr <= writePtr + 1'b1;
			end
			if (pop) begin
				readPtr <= readPtr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Head of queue, no full flag since callers reserve room by credit
	assign dataOut = mem[readPtr];
	assign empty = (count == '0);

endmodule

/* hw/paramDecode.sv */
// Parameter fetch stage
// Reads the length and multiplier registers when the host starts a run,
// then hands both values to the streaming stages and waits for completion
`timescale 1ns/1ps

module paramDecode import hostPkg::*, gfMathPkg::*; (
	input logic clk,
	input logic reset,
	input logic runValue,
	input logic regAck,
	input logic regReadValid,
	input hostWordT regReadData,
	input logic runDone,
	output logic regReq,
	output regAddrT regAddr,
	output memAddrT runLength,
	output gfElemT runMultiplier,
	output logic paramsReady
);

	decodeStateT state;
	// First returned word is the length, second the multiplier
	logic lengthSeen;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= decodeIdle;
			regReq <= 1'b0;
			regAddr <= lengthRegIndex;
			lengthSeen <= 1'b0;
			paramsReady <= 1'b0;
		end else begin
			// Single-cycle strobe
			paramsReady <= 1'b0;
			unique case (state)
				decodeIdle: begin
					if (runValue) begin
						state <= decodeFetching;
						regReq <= 1'b1;
						regAddr <= lengthRegIndex;
						lengthSeen <= 1'b0;
					end
				end
				decodeFetching: begin
					// Two requests back to back
					if (regReq && regAck) begin
						if (regAddr == lengthRegIndex) begin
							regAddr <= multiplierRegIndex;
						end else begin
							regReq <= 1'b0;
						end
					end
					// Returns come back in request order
					if (regReadValid) begin
						if (!lengthSeen) begin
							lengthSeen <= 1'b1;
						end else begin
							paramsReady <= 1'b1;
							state <= decodeRunning;
						end
					end
				end
				decodeRunning: begin
					// Held here so a run value still high cannot restart
					if (runDone) begin
						state <= decodeIdle;
					end
				end
				default: state <= decodeIdle;
			endcase
		end
	end

	// Returned values, stable for the whole run
	always_ff @(posedge clk) begin
		if (state == decodeFetching && regReadValid) begin
			if (!lengthSeen) begin
				// Oversized lengths saturate below the count word
				if (regReadData > hostWordT'(maxLength)) begin
					runLength <= maxLength;
				end else begin
					runLength <= regReadData[$bits(memAddrT)-1:0];
				end
			end else begin
				runMultiplier <= regReadData[$bits(gfElemT)-1:0];
			end
		end
	end

endmodule

/* hw/gfScaleExecute.sv */
// Input streaming and GF(2^8) scaling stage
// Issues credit-limited reads of the input memory, buffers the returned words
// and multiplies each byte lane by the run multiplier into a result register
`timescale 1ns/1ps

module gfScaleExecute import hostPkg::*, gfMathPkg::*; (
	input logic clk,
	input logic reset,
	input logic paramsReady,
	input memAddrT runLength,
	input gfElemT runMultiplier,
	input logic inReadAck,
	input logic inReadValid,
	input hostWordT inReadData,
	input logic outputRoom,
	output logic inReadReq,
	output memAddrT inReadAddr,
	output gfWordT scaledWord,
	output logic scaledValid
);

	// Shift-and-add product, the doubled operand is reduced mod fieldPoly
	function automatic gfElemT gfMul(input gfElemT a, input gfElemT b);
		gfElemT product;
		gfElemT shifted;
		logic [8:0] doubled;
		product = '0;
		shifted = a;
		for (int bitIdx = 0; bitIdx < $bits(gfElemT); bitIdx++) begin
			if (b[bitIdx]) begin
				product = product ^ shifted;
			end
			doubled = {shifted, 1'b0};
			if (doubled[8]) begin
				doubled = doubled ^ fieldPoly;
			end
			shifted = doubled[7:0];
		end
		return product;
	endfunction

	// Read side bookkeeping
	logic fetchActive;
	fifoCountT pendingReads;
	logic readAccept;
	logic [fifoLogDepth+1:0] creditUsed;

	// Input buffer side
	hostWordT bufferOut;
	logic bufferEmpty;
	fifoCountT bufferCount;
	logic bufferPop;
	gfWordT laneWord;

	assign readAccept = inReadReq && inReadAck;

	// Words in flight plus words waiting, one slot kept in reserve
	assign creditUsed = {1'b0, pendingReads} + {1'b0, bufferCount};
	assign inReadReq = fetchActive && (creditUsed < ((1 << fifoLogDepth) - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			fetchActive <= 1'b0;
			inReadAddr <= '0;
			pendingReads <= '0;
		end else begin
			if (paramsReady) begin
				// Nothing to fetch for a zero length
				fetchActive <= (runLength != '0);
				inReadAddr <= '0;
			end else if (readAccept) begin
				if (inReadAddr == memAddrT'(runLength - 1'b1)) begin
					fetchActive <= 1'b0;
				end else begin
					inReadAddr <= inReadAddr + 1'b1;
				end
			end
			// Accepted reads add, returned data removes
			if (readAccept && !inReadValid) begin
				pendingReads <= pendingReads + 1'b1;
			end else if (inReadValid && !readAccept) begin
				pendingReads <= pendingReads - 1'b1;
			end
		end
	end

	streamFifo #(
		.dataWidth($bits(hostWordT)),
		.logDepth(fifoLogDepth)
	) inputBuffer (
		.clk(clk),
		.reset(reset),
		.dataIn(inReadData),
		.push(inReadValid),
		.pop(bufferPop),
		.dataOut(bufferOut),
		.empty(bufferEmpty),
		.count(bufferCount)
	);

	// Advance only while the writer can take the product
	assign bufferPop = !bufferEmpty && outputRoom;
	assign laneWord = gfWordT'(bufferOut);

	always_ff @(posedge clk) begin
		if (reset) begin
			scaledValid <= 1'b0;
		end else begin
			scaledValid <= bufferPop;
		end
	end

	// Lanes are independent
	always_ff @(posedge clk) begin
		if (bufferPop) begin
			for (int lane = 0; lane < laneCount; lane++) begin
				scaledWord[lane] <= gfMul(laneWord[lane], runMultiplier);
			end
		end
	end

endmodule

/* hw/resultWriter.sv */
// Result writing stage
// Buffers scaled words, writes them to ascending output addresses,
// then reports the run's cycle count at the top address and ends the run
`timescale 1ns/1ps

module resultWriter import hostPkg::*, gfMathPkg::*; (
	input logic clk,
	input logic reset,
	input logic paramsReady,
	input memAddrT runLength,
	input gfWordT scaledWord,
	input logic scaledValid,
	input logic outWriteAck,
	output logic outWriteReq,
	output memAddrT outWriteAddr,
	output hostWordT outWriteData,
	output logic outputRoom,
	output logic runClear,
	output logic runDone
);

	writerStateT state;
	hostWordT cycleCount;
	// Address given to the next word taken from the buffer
	memAddrT popIndex;
	memAddrT lastAddr;
	logic writeDone;

	hostWordT bufferOut;
	logic bufferEmpty;
	fifoCountT bufferCount;
	logic bufferPop;

	streamFifo #(
		.dataWidth($bits(gfWordT)),
		.logDepth(fifoLogDepth)
	) outputBuffer (
		.clk(clk),
		.reset(reset),
		.dataIn(scaledWord),
		.push(scaledValid),
		.pop(bufferPop),
		.dataOut(bufferOut),
		.empty(bufferEmpty),
		.count(bufferCount)
	);

	// Two free slots cover the product already in the multiply register
	assign outputRoom = bufferCount < fifoCountT'((1 << fifoLogDepth) - 1);

	assign writeDone = outWriteReq && outWriteAck;
	assign lastAddr = memAddrT'(runLength - 1'b1);
	// New word when the bus is free or being freed this cycle
	assign bufferPop = (state == writerStreaming) && !bufferEmpty && (!outWriteReq || writeDone);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= writerFinishing;
			outWriteReq <= 1'b0;
			runClear <= 1'b0;
			popIndex <= '0;
			cycleCount <= '0;
		end else begin
			runClear <= 1'b0;
			// Cycle count covers everything after paramsReady
			if (state != writerFinishing) begin
				cycleCount <= cycleCount + 1'b1;
			end
			unique case (state)
				writerStreaming: begin
					if (bufferPop) begin
						outWriteReq <= 1'b1;
						outWriteAddr <= popIndex;
						outWriteData <= bufferOut;
						popIndex <= popIndex + 1'b1;
					end else if (writeDone) begin
						outWriteReq <= 1'b0;
					end
					// Last data word acknowledged
					if (writeDone && outWriteAddr == lastAddr) begin
						state <= writerReporting;
					end
				end
				writerReporting: begin
					if (!outWriteReq) begin
						outWriteReq <= 1'b1;
						outWriteAddr <= cycleCountAddress;
						outWriteData <= cycleCount;
					end else if (writeDone) begin
						outWriteReq <= 1'b0;
						runClear <= 1'b1;
						state <= writerFinishing;
					end
				end
				writerFinishing: begin
					if (paramsReady) begin
						popIndex <= '0;
						cycleCount <= hostWordT'(1);
						// Zero length only writes the count
						state <= (runLength == '0) ? writerReporting : writerStreaming;
					end
				end
				default: state <= writerFinishing;
			endcase
		end
	end

	assign runDone = runClear;

endmodule

/* hw/gfStreamTop.sv */
// GF(2^8) streaming accelerator top level
// Connects parameter fetch, scaling and result writing to the host
// register bus, the input memory and the output memory
`timescale 1ns/1ps

module gfStreamTop import hostPkg::*, gfMathPkg::*; (
	input logic clk,
	input logic reset,
	// Run control
	input logic runValue,
	output logic runClear,
	// Parameter registers
	output logic regReq,
	input logic regAck,
	output regAddrT regAddr,
	input logic regReadValid,
	input hostWordT regReadData,
	// Input memory
	output logic inReadReq,
	input logic inReadAck,
	output memAddrT inReadAddr,
	input logic inReadValid,
	input hostWordT inReadData,
	// Output memory
	output logic outWriteReq,
	input logic outWriteAck,
	output memAddrT outWriteAddr,
	output hostWordT outWriteData
);

	memAddrT runLength;
	gfElemT runMultiplier;
	logic paramsReady;
	gfWordT scaledWord;
	logic scaledValid;
	logic outputRoom;
	logic runDone;

	paramDecode paramDecode_inst (
		.clk(clk),
		.reset(reset),
		.runValue(runValue),
		.regAck(regAck),
		.regReadValid(regReadValid),
		.regReadData(regReadData),
		.runDone(runDone),
		.regReq(regReq),
		.regAddr(regAddr),
		.runLength(runLength),
		.runMultiplier(runMultiplier),
		.paramsReady(paramsReady)
	);

	gfScaleExecute gfScaleExecute_inst (
		.clk(clk),
		.reset(reset),
		.paramsReady(paramsReady),
		.runLength(runLength),
		.runMultiplier(runMultiplier),
		.inReadAck(inReadAck),
		.inReadValid(inReadValid),
		.inReadData(inReadData),
		.outputRoom(outputRoom),
		.inReadReq(inReadReq),
		.inReadAddr(inReadAddr),
		.scaledWord(scaledWord),
		.scaledValid(scaledValid)
	);

	resultWriter resultWriter_inst (
		.clk(clk),
		.reset(reset),
		.paramsReady(paramsReady),
		.runLength(runLength),
		.scaledWord(scaledWord),
		.scaledValid(scaledValid),
		.outWriteAck(outWriteAck),
		.outWriteReq(outWriteReq),
		.outWriteAddr(outWriteAddr),
		.outWriteData(outWriteData),
		.outputRoom(outputRoom),
		.runClear(runClear),
		.runDone(runDone)
	);

endmodule

/* testbench/gfStream_chk.sv */
// Handshake checks bound into the accelerator top level
// Output write hold, runClear width and register fetch order
`timescale 1ns/1ps

module gfStreamChk import hostPkg::*; (
	input logic clk,
	input logic reset,
	input logic runClear,
	input logic regReq,
	input logic regAck,
	input regAddrT regAddr,
	input logic outWriteReq,
	input logic outWriteAck,
	input memAddrT outWriteAddr,
	input hostWordT outWriteData
);

	// Request, address and data held until acknowledged
	property writeHeld;
		@(posedge clk) disable iff (reset)
		outWriteReq && !outWriteAck |=>
			outWriteReq && $stable(outWriteAddr) && $stable(outWriteData);
	endproperty

	assert property (writeHeld)
	else $error("output write dropped or changed before its acknowledge");

	// Single-cycle strobe
	assert property (@(posedge clk) disable iff (reset) runClear |=> !runClear)
	else $error("runClear high for more than one cycle");

	// A fetch opens at the length register
	assert property (@(posedge clk) disable iff (reset)
		$rose(regReq) |-> regAddr == lengthRegIndex)
	else $error("register fetch did not start at the length register");

	// Address held while the register bus stalls
	assert property (@(posedge clk) disable iff (reset)
		regReq && !regAck |=> regReq && $stable(regAddr))
	else $error("register request dropped or moved before it was accepted");

	// Accepted length request moves on to the multiplier
	assert property (@(posedge clk) disable iff (reset)
		regReq && regAck && regAddr == lengthRegIndex |=>
			regReq && regAddr == multiplierRegIndex)
	else $error("multiplier request did not follow the length request");

	// Accepted multiplier request ends the fetch
	assert property (@(posedge clk) disable iff (reset)
		regReq && regAck && regAddr == multiplierRegIndex |=> !regReq)
	else $error("register request still high after the multiplier request");

endmodule

bind gfStreamTop gfStreamChk handshakeChecks (
	.clk(clk),
	.reset(reset),
	.runClear(runClear),
	.regReq(regReq),
	.regAck(regAck),
	.regAddr(regAddr),
	.outWriteReq(outWriteReq),
	.outWriteAck(outWriteAck),
	.outWriteAddr(outWriteAddr),
	.outWriteData(outWriteData)
);

/* testbench/gfStreamTb.sv */
// Testbench for the GF(2^8) streaming accelerator
// Models the register file and both memories, runs every case of the case file
// and checks output words, write order, the cycle count and run completion
`timescale 1ns/1ps

module gfStreamTb import hostPkg::*; ();

	// x^8 + x^4 + x^3 + x + 1
	localparam logic [8:0] reductionPoly = 9'h11B;
	localparam int caseWordLimit = 256;
	localparam int memWords = 1 << $bits(memAddrT);
	localparam int resetCycles = 16;
	localparam int runTimeout = 20000;
	localparam int idleCycles = 8;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic runValue = 1'b0;
	logic runClear;
	logic regReq;
	logic regAck = 1'b0;
	regAddrT regAddr;
	logic regReadValid = 1'b0;
	hostWordT regReadData = '0;
	logic inReadReq;
	logic inReadAck = 1'b0;
	memAddrT inReadAddr;
	logic inReadValid = 1'b0;
	hostWordT inReadData = '0;
	logic outWriteReq;
	logic outWriteAck = 1'b0;
	memAddrT outWriteAddr;
	hostWordT outWriteData;

	// Case file image and memory models
	hostWordT caseWords [0:caseWordLimit-1];
	hostWordT inputMem [0:memWords-1];
	hostWordT outputMem [0:memWords-1];
	hostWordT expectedMem [0:memWords-1];
	logic [15:0] lfsrState = 16'd7802;
	// Current case and its stall levels
	// Low nibble stalls the register bus, the next two the input and output memories
	int caseLength = 0;
	hostWordT caseMultiplier = '0;
	hostWordT stallMask = '0;
	// One stage ahead of the read-data-valid outputs
	logic regStageValid = 1'b0;
	hostWordT regStageData = '0;
	logic inStageValid = 1'b0;
	hostWordT inStageData = '0;
	// Per-run bookkeeping
	int readCount = 0;
	int writeCount = 0;
	logic countSeen = 1'b0;
	hostWordT countValue = '0;

	always #10 clk = ~clk;

	gfStreamTop gfStreamTop_inst (
		.clk(clk),
		.reset(reset),
		.runValue(runValue),
		.runClear(runClear),
		.regReq(regReq),
		.regAck(regAck),
		.regAddr(regAddr),
		.regReadValid(regReadValid),
		.regReadData(regReadData),
		.inReadReq(inReadReq),
		.inReadAck(inReadAck),
		.inReadAddr(inReadAddr),
		.inReadValid(inReadValid),
		.inReadData(inReadData),
		.outWriteReq(outWriteReq),
		.outWriteAck(outWriteAck),
		.outWriteAddr(outWriteAddr),
		.outWriteData(outWriteData)
	);

	task automatic failRun(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	function automatic string timedError(input string msg);
		return $sformatf("[ERROR] %0t: %s", $time, msg);
	endfunction

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic feedback;
		feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], feedback};
	endfunction

	// One LFSR step per bit taken
	task automatic takeBits(input int width, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	// Stall when four random bits fall below the line's level
	task automatic drawStall(input logic [3:0] level, output logic stall);
		logic [31:0] bits;
		takeBits(4, bits);
		stall = bits[3:0] < level;
	endtask

	// Multiply by x and fold x^8 back through the polynomial
	function automatic logic [7:0] xtime(input logic [7:0] x);
		return {x[6:0], 1'b0} ^ (x[7] ? reductionPoly[7:0] : 8'h00);
	endfunction

	// Horner form taking the multiplier bits from the top
	function automatic logic [7:0] gfProduct(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] acc;
		acc = 8'h00;
		for (int i = 7; i >= 0; i--) begin
			acc = xtime(acc);
			if (b[i]) begin
				acc = acc ^ a;
			end
		end
		return acc;
	endfunction

	function automatic hostWordT scaleWord(input hostWordT w, input logic [7:0] m);
		hostWordT result;
		for (int lane = 0; lane < 4; lane++) begin
			result[lane*8 +: 8] = gfProduct(w[lane*8 +: 8], m);
		end
		return result;
	endfunction

	// Data words ascend from address 0 and the count comes last
	task automatic recordWrite(input memAddrT addr, input hostWordT data);
		assert (!countSeen) else begin
			failRun(timedError($sformatf("write to %0d after the cycle count", addr)));
		end
		if (addr == cycleCountAddress) begin
			assert (writeCount == caseLength) else begin
				failRun(timedError($sformatf("cycle count written after %0d of %0d words",
					writeCount, caseLength)));
			end
			countSeen = 1'b1;
			countValue = data;
		end else begin
			assert (int'(addr) == writeCount && writeCount < caseLength) else begin
				failRun(timedError($sformatf("write to %0d, expected address %0d",
					addr, writeCount)));
			end
			outputMem[addr] = data;
			writeCount++;
		end
	endtask

	// Host side of all three buses for one rising edge
	task automatic serviceHost();
		logic stall;
		// Returns staged on the previous edge show up now
		regReadValid <= regStageValid;
		regReadData <= regStageData;
		inReadValid <= inStageValid;
		inReadData <= inStageData;
		regStageValid = regReq && regAck;
		case (regAddr)
			lengthRegIndex: regStageData = hostWordT'(caseLength);
			multiplierRegIndex: regStageData = caseMultiplier;
			default: regStageData = '0;
		endcase
		inStageValid = inReadReq && inReadAck;
		if (inStageValid) begin
			assert (int'(inReadAddr) == readCount && readCount < caseLength) else begin
				failRun(timedError($sformatf("input read at %0d, expected %0d",
					inReadAddr, readCount)));
			end
			inStageData = inputMem[inReadAddr];
			readCount++;
		end
		if (outWriteReq && outWriteAck) begin
			recordWrite(outWriteAddr, outWriteData);
		end
		drawStall(stallMask[3:0], stall);
		regAck <= !stall;
		drawStall(stallMask[7:4], stall);
		inReadAck <= !stall;
		drawStall(stallMask[11:8], stall);
		outWriteAck <= !stall;
	endtask

	task automatic tick();
		@(posedge clk);
		serviceHost();
	endtask

	task automatic runCase(input int caseIndex);
		logic finished;
		readCount = 0;
		writeCount = 0;
		countSeen = 1'b0;
		finished = 1'b0;
		// Held high until runClear shows up
		runValue <= 1'b1;
		for (int cycle = 0; cycle < runTimeout && !finished; cycle++) begin
			tick();
			finished = runClear;
		end
		assert (finished) else begin
			failRun($sformatf("Timed out waiting for runClear in case %0d", caseIndex));
		end
		runValue <= 1'b0;
		assert (countSeen && countValue > hostWordT'(caseLength)) else begin
			failRun(timedError($sformatf("case %0d cycle count %0d missing or too small",
				caseIndex, countValue)));
		end
		assert (writeCount == caseLength && readCount == caseLength) else begin
			failRun(timedError($sformatf("case %0d moved %0d reads and %0d writes for %0d words",
				caseIndex, readCount, writeCount, caseLength)));
		end
		for (int addr = 0; addr < caseLength; addr++) begin
			assert (outputMem[addr] == expectedMem[addr]) else begin
				failRun(timedError($sformatf("case %0d address %0d holds %08h, expected %08h",
					caseIndex, addr, outputMem[addr], expectedMem[addr])));
			end
		end
		// runValue is low now so nothing may restart
		for (int cycle = 0; cycle < idleCycles; cycle++) begin
			tick();
			assert (!regReq && !runClear) else begin
				failRun(timedError($sformatf("activity after the end of case %0d", caseIndex)));
			end
		end
	endtask

	initial begin
		int pos;
		int caseIndex;
		int vectorCount;
		hostWordT randomWord;
		$readmemh("testbench/gfStreamCases.txt", caseWords);
		for (int i = 0; i < resetCycles; i++) begin
			tick();
		end
		reset <= 1'b0;
		tick();
		assert (!regReq && !inReadReq && !outWriteReq && !runClear) else begin
			failRun(timedError("request or runClear high after reset"));
		end
		pos = 0;
		caseIndex = 0;
		while (pos < caseWordLimit - 4 && caseWords[pos] != 32'hffffffff) begin
			caseLength = int'(caseWords[pos]);
			caseMultiplier = caseWords[pos + 1];
			stallMask = caseWords[pos + 2];
			vectorCount = int'(caseWords[pos + 3]);
			pos = pos + 4;
			// Leading words come from the file and the rest from the LFSR
			for (int addr = 0; addr < caseLength; addr++) begin
				if (addr < vectorCount) begin
					inputMem[addr] = caseWords[pos];
					expectedMem[addr] = caseWords[pos + 1];
					pos = pos + 2;
				end else begin
					takeBits(32, randomWord);
					inputMem[addr] = randomWord;
					expectedMem[addr] = scaleWord(randomWord, caseMultiplier[7:0]);
				end
			end
			runCase(caseIndex);
			caseIndex++;
		end
		assert (caseIndex > 0) else begin
			failRun("No cases were read from the case file");
		end
		$display("Completed %0d cases", caseIndex);
		$display(">>> PASS");
		$finish;
	end

endmodule

/* testbench/gfStreamCases.txt */
// case line: length multiplier stallMask vectorCount, stallMask nibbles write read register
// vector line: inputWord expectedProduct, filling input addresses from 0, ffffffff ends the list
00000028 00000001 00000000 00000003
12345678 12345678
deadbeef deadbeef
00ff80a5 00ff80a5
00000018 00000000 00000444 00000002
cafef00d 00000000
ffffffff 00000000
00000040 00000002 00000cc4 00000002
578001ff ae1b02e5
ae478e07 478e070e
00000000 00000005 00000080 00000000
00000064 00000113 000003a2 00000003
57575757 fefefefe
01028057 132643fe
00000000 00000000
00000078 000000ff 00000f01 00000002
00010001 00ff00ff
02020202 e5e5e5e5
00000032 0000001b 000000f0 00000000
ffffffff

/* compile.f */
hw/hostPkg.sv
hw/gfMathPkg.sv
hw/streamFifo.sv
hw/paramDecode.sv
hw/gfScaleExecute.sv
hw/resultWriter.sv
hw/gfStreamTop.sv
testbench/gfStream_chk.sv
testbench/gfStreamTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the GF(2^8) streaming accelerator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -Wno-fatal --top-module gfStreamTb \
	-f compile.f --Mdir build -o gfStreamSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./build/gfStreamSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0
